// File: verilog/calc_cfg_pkg.sv
package calc_cfg_pkg;

    // datapath width of one stored value
    localparam int DATA_W = 8;

    // register file geometry
    localparam int REG_DEPTH = 32;
    localparam int ADDR_W = $clog2(REG_DEPTH);

    // each calculation takes three slots for a, b and result
    localparam int SLOT_FIRST = 1;

    // last base that still fits a, b and result below REG_DEPTH
    localparam int SLOT_LAST_BASE = 28;

    // keypad code width
    localparam int KEY_W = 4;

    // status leds
    localparam int LED_W = 16;

endpackage

// File: verilog/calc_ctrl_pkg.sv
package calc_ctrl_pkg;

    // step codes shown on led_o[15:11]
    typedef enum logic [4:0] {
        wait_a    = 5'd0,
        check_a   = 5'd1,
        error_a   = 5'd2,
        store_a   = 5'd3,
        read_a    = 5'd4,
        show_a    = 5'd5,
        wait_op   = 5'd6,
        check_op  = 5'd7,
        error_op  = 5'd8,
        hold_op   = 5'd9,
        wait_b    = 5'd10,
        check_b   = 5'd11,
        error_b   = 5'd12,
        store_b   = 5'd13,
        read_b    = 5'd14,
        show_b    = 5'd15,
        wait_ent  = 5'd16,
        check_ent = 5'd17,
        error_ent = 5'd18,
        load      = 5'd19,
        compute   = 5'd20,
        store_res = 5'd21,
        read_res  = 5'd22,
        show_res  = 5'd23,
        next      = 5'd24
    } calc_step_e;

    // keypad codes
    localparam logic [3:0] key_max_digit = 4'd9;
    localparam logic [3:0] key_enter = 4'd15;

    // operator keys double as alu operation codes
    typedef enum logic [3:0] {
        op_add = 4'd10,
        op_sub = 4'd11,
        op_and = 4'd12,
        op_or  = 4'd13,
        op_xor = 4'd14
    } alu_op_e;

endpackage

// File: verilog/calc_alu.sv
`timescale 1ns/1ns

module calc_alu #(
    parameter int DATA_W = calc_cfg_pkg::DATA_W
) (
    input  logic                   clk_i,
    input  logic                   store_i,
    input  calc_ctrl_pkg::alu_op_e op_i,
    input  logic [DATA_W-1:0]      a_i,
    input  logic [DATA_W-1:0]      b_i,
    output logic [DATA_W-1:0]      result_o
);
    import calc_ctrl_pkg::*;

    always_comb begin
        case (op_i)
            op_add: begin
                result_o = a_i + b_i;
            end
            // wraps modulo 2**DATA_W when b is larger
            op_sub: begin
                result_o = a_i - b_i;
            end
            op_and: begin
                result_o = a_i & b_i;
            end
            op_or: begin
                result_o = a_i | b_i;
            end
            op_xor: begin
                result_o = a_i ^ b_i;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

    // a stored result must come from one of the five operators
    op_known_on_store: assert property (
        @(posedge clk_i)
        store_i |-> op_i inside {op_add, op_sub, op_and, op_or, op_xor}
    );

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ns

module reg_file #(
    parameter int DATA_W = calc_cfg_pkg::DATA_W,
    parameter int REG_DEPTH = calc_cfg_pkg::REG_DEPTH,
    localparam int ADDR_W = $clog2(REG_DEPTH)
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              wr_en_i,
    input  logic [ADDR_W-1:0] wr_addr_i,
    input  logic [DATA_W-1:0] wr_data_i,
    input  logic [ADDR_W-1:0] rd_addr_a_i,
    input  logic [ADDR_W-1:0] rd_addr_b_i,
    output logic [DATA_W-1:0] rd_data_a_o,
    output logic [DATA_W-1:0] rd_data_b_o
);

    logic [DATA_W-1:0] regs [REG_DEPTH];

    // all slots cleared on reset
    always_ff @(posedge clk_i, posedge reset_i) begin
        if (reset_i) begin
            for (int i = 0; i < REG_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // combinational read ports
    assign rd_data_a_o = regs[rd_addr_a_i];
    assign rd_data_b_o = regs[rd_addr_b_i];

    wr_addr_in_range: assert property (
        @(posedge clk_i) disable iff (reset_i)
        wr_en_i |-> int'(wr_addr_i) < REG_DEPTH
    );

endmodule

// File: verilog/calc_sequencer.sv
`timescale 1ns/1ns

module calc_sequencer #(
    parameter int DATA_W = calc_cfg_pkg::DATA_W,
    parameter int ADDR_W = calc_cfg_pkg::ADDR_W
) (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic [calc_cfg_pkg::KEY_W-1:0] key_i,
    input  logic                           key_valid_i,
    input  logic [DATA_W-1:0]              alu_result_i,
    output logic                           wr_en_o,
    output logic [ADDR_W-1:0]              wr_addr_o,
    output logic [ADDR_W-1:0]              rd_addr_a_o,
    output logic [ADDR_W-1:0]              rd_addr_b_o,
    output logic [DATA_W-1:0]              wr_data_o,
    output calc_ctrl_pkg::alu_op_e         alu_op_o,
    output logic                           alu_store_o,
    output logic [calc_cfg_pkg::LED_W-1:0] led_o,
    output logic                           disp_we_o
);
    import calc_cfg_pkg::*;
    import calc_ctrl_pkg::*;

    calc_step_e        step_q;
    calc_step_e        step_d;
    logic [KEY_W-1:0]  key_q;
    logic [KEY_W-1:0]  op_q;
    logic [ADDR_W-1:0] base_q;
    logic [ADDR_W-1:0] slot_b;
    logic [ADDR_W-1:0] slot_res;
    logic              waiting;
    logic              key_is_digit;
    logic              key_is_op;
    logic              key_is_enter;

    assign waiting = step_q inside {wait_a, wait_op, wait_b, wait_ent};

    // key classes of the latched code
    assign key_is_digit = key_q <= key_max_digit;
    assign key_is_op = (key_q >= op_add) && (key_q <= op_xor);
    assign key_is_enter = key_q == key_enter;

    always_comb begin
        step_d = step_q;
        case (step_q)
            wait_a: begin
                if (key_valid_i) begin
                    step_d = check_a;
                end
            end
            check_a:   step_d = key_is_digit ? store_a : error_a;
            error_a:   step_d = wait_a;
            store_a:   step_d = read_a;
            read_a:    step_d = show_a;
            show_a:    step_d = wait_op;
            wait_op: begin
                if (key_valid_i) begin
                    step_d = check_op;
                end
            end
            check_op:  step_d = key_is_op ? hold_op : error_op;
            error_op:  step_d = wait_op;
            hold_op:   step_d = wait_b;
            wait_b: begin
                if (key_valid_i) begin
                    step_d = check_b;
                end
            end
            check_b:   step_d = key_is_digit ? store_b : error_b;
            error_b:   step_d = wait_b;
            store_b:   step_d = read_b;
            read_b:    step_d = show_b;
            show_b:    step_d = wait_ent;
            wait_ent: begin
                if (key_valid_i) begin
                    step_d = check_ent;
                end
            end
            check_ent: step_d = key_is_enter ? load : error_ent;
            error_ent: step_d = wait_ent;
            // operands settle through the read ports and the alu
            load:      step_d = compute;
            compute:   step_d = store_res;
            store_res: step_d = read_res;
            read_res:  step_d = show_res;
            show_res:  step_d = next;
            next:      step_d = wait_a;
            default:   step_d = wait_a;
        endcase
    end

    always_ff @(posedge clk_i, posedge reset_i) begin
        if (reset_i) begin
            step_q <= wait_a;
            op_q <= '0;
            base_q <= ADDR_W'(SLOT_FIRST);
        end else begin
            step_q <= step_d;
            if (step_q == check_op && key_is_op) begin
                op_q <= key_q;
            end else if (step_q == next) begin
                op_q <= '0;
            end
            // move on to the next three slots and wrap after the last base
            if (step_q == next) begin
                if (base_q == ADDR_W'(SLOT_LAST_BASE)) begin
                    base_q <= ADDR_W'(SLOT_FIRST);
                end else begin
                    base_q <= base_q + ADDR_W'(3);
                end
            end
        end
    end

    // key only sampled while waiting
    always_ff @(posedge clk_i) begin
        if (waiting && key_valid_i) begin
            key_q <= key_i;
        end
    end

    assign slot_b = base_q + ADDR_W'(1);
    assign slot_res = base_q + ADDR_W'(2);

    assign wr_en_o = step_q inside {store_a, store_b, store_res};

    always_comb begin
        case (step_q)
            store_b:   wr_addr_o = slot_b;
            store_res: wr_addr_o = slot_res;
            default:   wr_addr_o = base_q;
        endcase
    end

    assign wr_data_o = (step_q == store_res) ? alu_result_i : DATA_W'(key_q);

    assign rd_addr_a_o = base_q;

    // port b reads back whatever slot was just written
    always_comb begin
        case (step_q)
            read_a, show_a:     rd_addr_b_o = base_q;
            read_res, show_res: rd_addr_b_o = slot_res;
            default:            rd_addr_b_o = slot_b;
        endcase
    end

    assign disp_we_o = step_q inside {show_a, show_b, show_res};

    assign alu_op_o = alu_op_e'(op_q);
    assign alu_store_o = step_q == store_res;

    always_comb begin
        if (step_q == next) begin
            led_o = '1;
        end else begin
            led_o = '0;
            led_o[15:11] = step_q;
            led_o[9:6] = op_q;
            led_o[0] = step_q inside {error_a, error_op, error_b, error_ent};
        end
    end

    wr_disp_excl: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !(wr_en_o && disp_we_o)
    );

    wr_addr_nonzero: assert property (
        @(posedge clk_i) disable iff (reset_i)
        wr_en_o |-> wr_addr_o != '0
    );

endmodule

// File: verilog/calc_top.sv
`timescale 1ns/1ns

module calc_top #(
    parameter int DATA_W = calc_cfg_pkg::DATA_W,
    parameter int REG_DEPTH = calc_cfg_pkg::REG_DEPTH,
    localparam int ADDR_W = $clog2(REG_DEPTH)
) (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic [calc_cfg_pkg::KEY_W-1:0] key_i,
    input  logic                           key_valid_i,
    output logic [calc_cfg_pkg::LED_W-1:0] led_o,
    output logic                           disp_we_o,
    output logic [DATA_W-1:0]              disp_data_o
);
    import calc_ctrl_pkg::*;

    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;
    logic [ADDR_W-1:0] rd_addr_a;
    logic [ADDR_W-1:0] rd_addr_b;
    logic [DATA_W-1:0] rd_data_a;
    logic [DATA_W-1:0] rd_data_b;
    logic [DATA_W-1:0] alu_result;
    logic              alu_store;
    alu_op_e           alu_op;

    calc_sequencer #(
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W)
    ) u_sequencer (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .key_i        (key_i),
        .key_valid_i  (key_valid_i),
        .alu_result_i (alu_result),
        .wr_en_o      (wr_en),
        .wr_addr_o    (wr_addr),
        .rd_addr_a_o  (rd_addr_a),
        .rd_addr_b_o  (rd_addr_b),
        .wr_data_o    (wr_data),
        .alu_op_o     (alu_op),
        .alu_store_o  (alu_store),
        .led_o        (led_o),
        .disp_we_o    (disp_we_o)
    );

    reg_file #(
        .DATA_W    (DATA_W),
        .REG_DEPTH (REG_DEPTH)
    ) u_reg_file (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .wr_en_i     (wr_en),
        .wr_addr_i   (wr_addr),
        .wr_data_i   (wr_data),
        .rd_addr_a_i (rd_addr_a),
        .rd_addr_b_i (rd_addr_b),
        .rd_data_a_o (rd_data_a),
        .rd_data_b_o (rd_data_b)
    );

    calc_alu #(
        .DATA_W (DATA_W)
    ) u_alu (
        .clk_i    (clk_i),
        .store_i  (alu_store),
        .op_i     (alu_op),
        .a_i      (rd_data_a),
        .b_i      (rd_data_b),
        .result_o (alu_result)
    );

    // display shows read port b
    assign disp_data_o = rd_data_b;

endmodule

// File: dv/calc_tb_checks.svh
`ifndef CALC_TB_CHECKS_SVH
`define CALC_TB_CHECKS_SVH

// calculator idle and dark once reset is released
reset_state: assert property (
    @(posedge clk_i)
    $fell(reset_i) |-> led_o == '0 && !disp_we_o
) else stop_with_error($sformatf("FAILED at %0t ns: led_o %h after reset, expected 0",
    $time, led_o));

// every display pulse carries the expected digit or result
disp_value: assert property (
    @(posedge clk_i) disable iff (reset_i)
    disp_we_o |-> !expect_err && disp_data_o == exp_disp
) else stop_with_error($sformatf("FAILED at %0t ns: display %0d, expected %0d (invalid key %0b)",
    $time, disp_data_o, exp_disp, expect_err));

// digit shows 4 edges after it is taken and the result 6 edges after enter
digit_latency: assert property (
    @(posedge clk_i) disable iff (reset_i)
    key_valid_i && led_o[15:11] inside {wait_a, wait_b} && key_i <= 4'd9 |-> ##4 disp_we_o
) else stop_with_error($sformatf("FAILED at %0t ns: no display pulse 4 cycles after digit",
    $time));

enter_latency: assert property (
    @(posedge clk_i) disable iff (reset_i)
    key_valid_i && led_o[15:11] == wait_ent && key_i == 4'd15 |-> ##6 disp_we_o
) else stop_with_error($sformatf("FAILED at %0t ns: no result pulse 6 cycles after enter",
    $time));

// operator leds only between hold_op and show_res
op_leds: assert property (
    @(posedge clk_i) disable iff (reset_i)
    led_o != '1 |->
        led_o[9:6] == ((led_o[15:11] >= hold_op && led_o[15:11] <= show_res) ? exp_op : 4'd0)
) else stop_with_error($sformatf("FAILED at %0t ns: operator leds %0d in step %0d, expected %0d",
    $time, led_o[9:6], led_o[15:11], exp_op));

err_expected: assert property (
    @(posedge clk_i) disable iff (reset_i)
    led_o[0] && led_o != '1 |-> expect_err
) else stop_with_error($sformatf("FAILED at %0t ns: error flag raised on a valid key", $time));

// invalid key reaches its error step two edges after it is taken
err_raised: assert property (
    @(posedge clk_i) disable iff (reset_i)
    key_valid_i && expect_err |-> ##2 led_o[0] && led_o != '1
) else stop_with_error($sformatf("FAILED at %0t ns: invalid key raised no error flag", $time));

// error step sits two codes above its wait step and falls back to it
err_returns: assert property (
    @(posedge clk_i) disable iff (reset_i)
    led_o[0] && led_o != '1 |->
        !disp_we_o && led_o[15:11] == exp_wait + 5'd2 ##1 led_o[15:11] == exp_wait
) else stop_with_error($sformatf("FAILED at %0t ns: error step %0d did not return to step %0d",
    $time, led_o[15:11], exp_wait));

result_then_next: assert property (
    @(posedge clk_i) disable iff (reset_i)
    disp_we_o && led_o[15:11] == show_res |=> led_o == '1 ##1 led_o == '0
) else stop_with_error($sformatf("FAILED at %0t ns: led_o %h after result, expected ones then 0",
    $time, led_o));

`endif

// File: dv/calc_tb.sv
`timescale 1ns/1ns

module calc_tb;
    import calc_cfg_pkg::*;
    import calc_ctrl_pkg::*;

    localparam int NUM_CALCS = 12;
    localparam int MAX_WAIT = 40;

    logic              clk_i;
    logic              reset_i;
    logic [KEY_W-1:0]  key_i;
    logic              key_valid_i;
    logic [LED_W-1:0]  led_o;
    logic              disp_we_o;
    logic [DATA_W-1:0] disp_data_o;

    // expectations read by the concurrent checks
    logic [DATA_W-1:0] exp_disp;
    logic [3:0]        exp_op;
    logic [4:0]        exp_wait;
    logic              expect_err;

    int seed;
    int results_seen = 0;

    calc_top #(
        .DATA_W    (DATA_W),
        .REG_DEPTH (REG_DEPTH)
    ) DUT (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .key_i       (key_i),
        .key_valid_i (key_valid_i),
        .led_o       (led_o),
        .disp_we_o   (disp_we_o),
        .disp_data_o (disp_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic stop_with_error(input string line);
        $display("TB FAILED");
        $display("%s", line);
        $fatal(1, "simulation stopped");
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // keypad arithmetic wrapping at the data width
    function automatic logic [DATA_W-1:0] model_result(input logic [3:0] op,
                                                       input logic [DATA_W-1:0] a,
                                                       input logic [DATA_W-1:0] b);
        case (op)
            4'd10:   return a + b;
            4'd11:   return a - b;
            4'd12:   return a & b;
            4'd13:   return a | b;
            4'd14:   return a ^ b;
            default: return '0;
        endcase
    endfunction

    task automatic press_key(input logic [3:0] code, input bit bad,
                             input logic [4:0] wait_code, input logic [DATA_W-1:0] show);
        int cycles;
        expect_err = bad;
        exp_wait = wait_code;
        exp_disp = show;
        key_i = code;
        key_valid_i = 1'b1;
        @(posedge clk_i);
        #1;
        key_valid_i = 1'b0;
        cycles = 0;
        // operator keys show nothing and end in wait_b
        while (!(disp_we_o || led_o[0] || led_o[15:11] == wait_b)) begin
            if (cycles == MAX_WAIT) begin
                stop_with_error($sformatf("timeout: key %0d gave no display, error or step", code));
            end
            @(posedge clk_i);
            #1;
            cycles++;
        end
        cycles = 0;
        while (!(led_o[15:11] inside {wait_a, wait_op, wait_b, wait_ent})) begin
            if (cycles == MAX_WAIT) begin
                stop_with_error($sformatf("timeout: no wait step reached after key %0d", code));
            end
            @(posedge clk_i);
            #1;
            cycles++;
        end
    endtask

    task automatic run_calc(input logic [3:0] op, input bit with_errors);
        logic [3:0] a;
        logic [3:0] b;
        a = 4'(rand_below(10));
        b = 4'(rand_below(10));
        if (with_errors) begin
            press_key(4'(10 + rand_below(5)), 1'b1, wait_a, '0);
        end
        press_key(a, 1'b0, wait_a, DATA_W'(a));
        if (with_errors) begin
            press_key(4'(rand_below(10)), 1'b1, wait_op, '0);
        end
        exp_op = op;
        press_key(op, 1'b0, wait_op, '0);
        if (with_errors) begin
            press_key(4'(10 + rand_below(5)), 1'b1, wait_b, '0);
        end
        press_key(b, 1'b0, wait_b, DATA_W'(b));
        if (with_errors) begin
            // anything but enter
            press_key(4'(rand_below(15)), 1'b1, wait_ent, '0);
        end
        press_key(4'd15, 1'b0, wait_ent, model_result(op, DATA_W'(a), DATA_W'(b)));
    endtask

    `include "calc_tb_checks.svh"

    // sampled away from the rising edge
    always @(negedge clk_i) begin
        if (disp_we_o && led_o[15:11] == show_res) begin
            results_seen++;
        end
    end

    initial begin
        logic [3:0] op;
        seed = 32'h0b79_8a49;
        reset_i = 1'b1;
        key_i = '0;
        key_valid_i = 1'b0;
        exp_disp = '0;
        exp_op = '0;
        exp_wait = wait_a;
        expect_err = 1'b0;
        repeat (2) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        // first five cover every operator and the rest are random
        for (int i = 0; i < NUM_CALCS; i++) begin
            if (i < 5) begin
                op = 4'(10 + i);
            end else begin
                op = 4'(10 + rand_below(5));
            end
            run_calc(op, i == 0 || i == 7);
        end
        if (results_seen == NUM_CALCS) begin
            $display("TB PASSED");
            $finish;
        end else begin
            stop_with_error($sformatf("FAILED at %0t ns: %0d results shown, expected %0d",
                $time, results_seen, NUM_CALCS));
        end
    end

endmodule

// File: vlog.f
+incdir+dv
verilog/calc_cfg_pkg.sv
verilog/calc_ctrl_pkg.sv
verilog/calc_alu.sv
verilog/reg_file.sv
verilog/calc_sequencer.sv
verilog/calc_top.sv
dv/calc_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the calculator testbench with verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary -j 0 --assert --timescale 1ns/1ns \
        --top-module calc_tb -f vlog.f -o calc_sim; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/calc_sim 2>&1)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TB PASSED" <<< "$out"; then
    exit 0
fi
exit 1
